//--- rtl/cart_pkg.sv
`default_nettype none

package cart_pkg;

	////////////////////////////////////////
	// Widths and memory map
	////////////////////////////////////////

	typedef logic [15:0] word_t;

	localparam int MEM_AW      = 15; // Lower half ROM, upper half work RAM
	localparam int ROM_AW      = 14;
	localparam int PAGE_OFS_W  = 9;  // 512 words per page
	localparam int PAGE_SEL_W  = 3;  // Eight CPU pages
	localparam int BANK_W      = 5;  // 32 physical pages

	localparam logic [24:0] HDR_REGION_ADDR = 25'h1F0;
	localparam int ROM_INDEX_MAX = 1;

	// Accept to valid, in clocks
	localparam int RAM_LATENCY = 2;

	////////////////////////////////////////
	// Enums
	////////////////////////////////////////

	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_e;

	typedef enum logic [1:0] {
		ARB_IDLE   = 2'd0, // Nothing in flight
		ARB_LOADER = 2'd1, // Loader write in flight
		ARB_CPU    = 2'd2  // CPU access in flight
	} arb_state_e;

endpackage

`default_nettype wire

//--- rtl/word_ram.sv
`timescale 1ns/1ps
`default_nettype none

module word_ram #(
	parameter int ADDR_W = 15
) (
	input  wire                   clk_sys,
	input  wire                   rst_n,
	input  wire                   ram_en,
	input  wire                   ram_we,
	input  wire [ADDR_W-1:0]      ram_addr,
	input  wire cart_pkg::word_t  ram_wdata,
	output cart_pkg::word_t       ram_rdata,
	output logic                  ram_valid
);

	localparam int LAT = cart_pkg::RAM_LATENCY;

	cart_pkg::word_t mem [2**ADDR_W];
	cart_pkg::word_t rd_q [LAT];
	logic [LAT-1:0] vld_q;

	// Strobe delay line, writes pulse valid too
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			vld_q <= '0;
		end else begin
			vld_q <= {vld_q[LAT-2:0], ram_en};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ram_en && ram_we)
			mem[ram_addr] <= ram_wdata; // Lands on the accept edge
		rd_q[0] <= mem[ram_addr];
		for (int i = 1; i < LAT; i++) begin
			rd_q[i] <= rd_q[i-1];
		end
	end

	assign ram_rdata = rd_q[LAT-1];
	assign ram_valid = vld_q[LAT-1];

endmodule

`default_nettype wire

//--- rtl/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
	input  wire                          clk_sys,
	input  wire                          rst_n,
	// Loader, writes only
	input  wire                          ld_req,
	input  wire [cart_pkg::ROM_AW-1:0]   ld_addr,
	input  wire cart_pkg::word_t         ld_wdata,
	output logic                         ld_done,
	// CPU through the bank mapper
	input  wire                          cpu_req,
	input  wire                          cpu_we,
	input  wire [cart_pkg::MEM_AW-1:0]   mem_addr,
	input  wire cart_pkg::word_t         mem_wdata,
	output logic                         cpu_done,
	output cart_pkg::word_t              mem_rdata,
	// Shared memory
	output logic                         ram_en,
	output logic                         ram_we,
	output logic [cart_pkg::MEM_AW-1:0]  ram_addr,
	output cart_pkg::word_t              ram_wdata,
	input  wire cart_pkg::word_t         ram_rdata,
	input  wire                          ram_valid
);

	cart_pkg::arb_state_e state_q;

	////////////////////////////////////////
	// Owner FSM, one access at a time
	////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= cart_pkg::ARB_IDLE;
			ram_en  <= 1'b0;
		end else begin
			ram_en <= 1'b0;
			case (state_q)
				cart_pkg::ARB_IDLE: begin
					if (ld_req) begin // Loader first
						state_q <= cart_pkg::ARB_LOADER;
						ram_en  <= 1'b1;
					end else if (cpu_req) begin
						state_q <= cart_pkg::ARB_CPU;
						ram_en  <= 1'b1;
					end
				end
				default: begin
					if (ram_valid)
						state_q <= cart_pkg::ARB_IDLE;
				end
			endcase
		end
	end

	// Access payload, captured with the strobe
	always_ff @(posedge clk_sys) begin
		if (state_q == cart_pkg::ARB_IDLE) begin
			if (ld_req) begin
				ram_we    <= 1'b1;
				ram_addr  <= {1'b0, ld_addr}; // ROM half
				ram_wdata <= ld_wdata;
			end else begin
				ram_we    <= cpu_we;
				ram_addr  <= mem_addr;
				ram_wdata <= mem_wdata;
			end
		end
	end

	// Completion goes back to whoever owns the slot
	assign ld_done   = (state_q == cart_pkg::ARB_LOADER) && ram_valid;
	assign cpu_done  = (state_q == cart_pkg::ARB_CPU) && ram_valid;
	assign mem_rdata = ram_rdata;

endmodule

`default_nettype wire

//--- rtl/rom_loader.sv
`timescale 1ns/1ps
`default_nettype none

module rom_loader (
	input  wire                          clk_sys,
	input  wire                          rst_n,
	// Host download port
	input  wire                          ioctl_download,
	input  wire [7:0]                    ioctl_index,
	input  wire                          ioctl_wr,
	input  wire [24:0]                   ioctl_addr,
	input  wire [15:0]                   ioctl_data,
	output logic                         ioctl_wait,
	// Memory requests
	output logic                         ld_req,
	output logic [cart_pkg::ROM_AW-1:0]  ld_addr,
	output cart_pkg::word_t              ld_wdata,
	input  wire                          ld_done,
	// Status for header and mapper
	output logic                         rom_download,
	output logic [cart_pkg::BANK_W-1:0]  page_mask
);

	logic accept;

	assign rom_download = ioctl_download &&
		(ioctl_index[5:0] <= 6'(cart_pkg::ROM_INDEX_MAX));

	// A write while wait is high is dropped
	assign accept = rom_download && ioctl_wr && !ioctl_wait;

	////////////////////////////////////////
	// Wait level and image size mask
	////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ioctl_wait <= 1'b0;
			page_mask  <= '0;
		end else begin
			if (accept) begin
				ioctl_wait <= 1'b1;
				if (ioctl_addr == '0)
					page_mask <= '0; // New image
				else
					page_mask <= page_mask | ioctl_addr[cart_pkg::ROM_AW -: cart_pkg::BANK_W];
			end else if (ld_done) begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	// Request is held exactly as long as the host is held off
	assign ld_req = ioctl_wait;

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			ld_addr  <= ioctl_addr[cart_pkg::ROM_AW:1];
			ld_wdata <= {ioctl_data[7:0], ioctl_data[15:8]}; // Big endian image
		end
	end

endmodule

`default_nettype wire

//--- rtl/cart_header.sv
`timescale 1ns/1ps
`default_nettype none

module cart_header (
	input  wire                clk_sys,
	input  wire                rst_n,
	input  wire                rom_download,
	input  wire                ioctl_wr,
	input  wire [24:0]         ioctl_addr,
	input  wire [15:0]         ioctl_data,
	output cart_pkg::region_e  region_req,
	output logic               region_set
);

	logic dl_q;
	logic hdr_j;
	logic hdr_u;
	logic hdr_wr;

	assign hdr_wr = rom_download && ioctl_wr && (ioctl_addr == cart_pkg::HDR_REGION_ADDR);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dl_q       <= 1'b0;
			hdr_j      <= 1'b0;
			hdr_u      <= 1'b0;
			region_set <= 1'b0;
		end else begin
			dl_q <= rom_download;

			// Forget the last image's region
			if (rom_download && !dl_q) begin
				hdr_j <= 1'b0;
				hdr_u <= 1'b0;
			end

			if (hdr_wr) begin
				hdr_j      <= (ioctl_data[7:0] == "J");
				hdr_u      <= (ioctl_data[7:0] == "U");
				region_set <= 1'b1;
			end

			if (dl_q && !rom_download)
				region_set <= 1'b0; // Download over
		end
	end

	// Anything not J or U is treated as Europe
	assign region_req = hdr_u ? cart_pkg::REGION_US :
		hdr_j ? cart_pkg::REGION_JP : cart_pkg::REGION_EU;

endmodule

`default_nettype wire

//--- rtl/bank_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module bank_mapper #(
	parameter int BANK_W     = 5,
	parameter int PAGE_OFS_W = 9
) (
	input  wire                          clk_sys,
	input  wire                          rst_n,
	input  wire                          rom_download,
	input  wire [BANK_W-1:0]             page_mask,
	// CPU port
	input  wire                          cpu_rd,
	input  wire                          cpu_wr,
	input  wire                          cpu_bank_wr,
	input  wire [cart_pkg::MEM_AW-1:0]   cpu_addr,
	input  wire cart_pkg::word_t         cpu_wdata,
	output cart_pkg::word_t              cpu_rdata,
	output logic                         cpu_busy,
	// Arbiter side
	output logic                         cpu_req,
	output logic                         cpu_we,
	output logic [cart_pkg::MEM_AW-1:0]  mem_addr,
	output cart_pkg::word_t              mem_wdata,
	input  wire                          cpu_done,
	input  wire cart_pkg::word_t         mem_rdata
);

	localparam int NBANK = 2 ** cart_pkg::PAGE_SEL_W;

	logic [BANK_W-1:0] bank_q [NBANK];
	logic [cart_pkg::PAGE_SEL_W-1:0] page_sel;
	logic [cart_pkg::PAGE_SEL_W-1:0] bank_idx;
	logic [BANK_W-1:0] phys_page;
	logic dl_q;
	logic is_wram;
	logic start;

	assign page_sel  = cpu_addr[PAGE_OFS_W +: cart_pkg::PAGE_SEL_W];
	assign bank_idx  = cpu_addr[cart_pkg::PAGE_SEL_W-1:0];
	assign phys_page = bank_q[page_sel] & page_mask;
	assign is_wram   = cpu_addr[cart_pkg::MEM_AW-1];

	// ROM writes are dropped here and never reach the arbiter
	assign start = !cpu_busy && (cpu_rd || (cpu_wr && is_wram));

	////////////////////////////////////////
	// Bank registers
	////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dl_q <= 1'b0;
			for (int i = 0; i < NBANK; i++) begin
				bank_q[i] <= BANK_W'(i);
			end
		end else begin
			dl_q <= rom_download;
			if (rom_download && !dl_q) begin
				for (int i = 0; i < NBANK; i++) begin
					bank_q[i] <= BANK_W'(i); // Identity map for a fresh image
				end
			end else if (cpu_bank_wr && bank_idx != '0 && page_mask[BANK_W-1]) begin
				bank_q[bank_idx] <= cpu_wdata[BANK_W-1:0]; // Only for large images
			end
		end
	end

	////////////////////////////////////////
	// Access tracking
	////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cpu_busy <= 1'b0;
		end else if (start) begin
			cpu_busy <= 1'b1;
		end else if (cpu_done) begin
			cpu_busy <= 1'b0;
		end
	end

	assign cpu_req = cpu_busy;

	always_ff @(posedge clk_sys) begin
		if (start) begin
			cpu_we    <= cpu_wr && is_wram;
			mem_wdata <= cpu_wdata;
			if (is_wram)
				mem_addr <= {1'b1, cpu_addr[cart_pkg::MEM_AW-2:0]};
			else
				mem_addr <= {1'b0, phys_page, cpu_addr[PAGE_OFS_W-1:0]};
		end
		if (cpu_done && !cpu_we)
			cpu_rdata <= mem_rdata; // Held until the next read
	end

endmodule

`default_nettype wire

//--- rtl/cart_loader_top.sv
`timescale 1ns/1ps
`default_nettype none

module cart_loader_top (
	input  wire                          clk_sys,
	input  wire                          rst_n,
	// Host download
	input  wire                          ioctl_download,
	input  wire [7:0]                    ioctl_index,
	input  wire                          ioctl_wr,
	input  wire [24:0]                   ioctl_addr,
	input  wire [15:0]                   ioctl_data,
	output logic                         ioctl_wait,
	// CPU
	input  wire                          cpu_rd,
	input  wire                          cpu_wr,
	input  wire                          cpu_bank_wr,
	input  wire [cart_pkg::MEM_AW-1:0]   cpu_addr,
	input  wire cart_pkg::word_t         cpu_wdata,
	output cart_pkg::word_t              cpu_rdata,
	output logic                         cpu_busy,
	// Region out
	output cart_pkg::region_e            region_req,
	output logic                         region_set
);

	logic                         rom_download;
	logic [cart_pkg::BANK_W-1:0]  page_mask;

	// Loader requests
	logic                         ld_req;
	logic [cart_pkg::ROM_AW-1:0]  ld_addr;
	cart_pkg::word_t              ld_wdata;
	logic                         ld_done;

	// CPU requests
	logic                         cpu_req;
	logic                         cpu_we;
	logic [cart_pkg::MEM_AW-1:0]  mem_addr;
	cart_pkg::word_t              mem_wdata;
	logic                         cpu_done;
	cart_pkg::word_t              mem_rdata;

	// Memory port
	logic                         ram_en;
	logic                         ram_we;
	logic [cart_pkg::MEM_AW-1:0]  ram_addr;
	cart_pkg::word_t              ram_wdata;
	cart_pkg::word_t              ram_rdata;
	logic                         ram_valid;

	////////////////////////////////////////
	// Download side
	////////////////////////////////////////

	rom_loader loader_i (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.ioctl_wait     (ioctl_wait),
		.ld_req         (ld_req),
		.ld_addr        (ld_addr),
		.ld_wdata       (ld_wdata),
		.ld_done        (ld_done),
		.rom_download   (rom_download),
		.page_mask      (page_mask)
	);

	cart_header header_i (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.rom_download (rom_download),
		.ioctl_wr     (ioctl_wr),
		.ioctl_addr   (ioctl_addr),
		.ioctl_data   (ioctl_data),
		.region_req   (region_req),
		.region_set   (region_set)
	);

	////////////////////////////////////////
	// CPU side and shared memory
	////////////////////////////////////////

	bank_mapper #(
		.BANK_W     (cart_pkg::BANK_W),
		.PAGE_OFS_W (cart_pkg::PAGE_OFS_W)
	) mapper_i (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.rom_download (rom_download),
		.page_mask    (page_mask),
		.cpu_rd       (cpu_rd),
		.cpu_wr       (cpu_wr),
		.cpu_bank_wr  (cpu_bank_wr),
		.cpu_addr     (cpu_addr),
		.cpu_wdata    (cpu_wdata),
		.cpu_rdata    (cpu_rdata),
		.cpu_busy     (cpu_busy),
		.cpu_req      (cpu_req),
		.cpu_we       (cpu_we),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.cpu_done     (cpu_done),
		.mem_rdata    (mem_rdata)
	);

	mem_arbiter arbiter_i (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.ld_req    (ld_req),
		.ld_addr   (ld_addr),
		.ld_wdata  (ld_wdata),
		.ld_done   (ld_done),
		.cpu_req   (cpu_req),
		.cpu_we    (cpu_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.cpu_done  (cpu_done),
		.mem_rdata (mem_rdata),
		.ram_en    (ram_en),
		.ram_we    (ram_we),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_rdata (ram_rdata),
		.ram_valid (ram_valid)
	);

	word_ram #(
		.ADDR_W (cart_pkg::MEM_AW)
	) ram_i (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.ram_en    (ram_en),
		.ram_we    (ram_we),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_rdata (ram_rdata),
		.ram_valid (ram_valid)
	);

endmodule

`default_nettype wire

//--- sim/tb_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module cart_assertions (
	input wire        clk_sys,
	input wire        rst_n,
	input wire        ioctl_download,
	input wire        ioctl_wait,
	input wire        cpu_rd,
	input wire        cpu_wr,
	input wire [14:0] cpu_addr,
	input wire        cpu_busy,
	input wire        region_set
);

	int fail_count = 0;

	// Both back-pressure levels idle out of reset
	idle_after_reset: assert property (@(posedge clk_sys)
		$rose(rst_n) |-> (!ioctl_wait && !cpu_busy))
		else begin
			fail_count++;
			$error("ioctl_wait or cpu_busy high right after reset");
		end

	busy_follows_strobe: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(!cpu_busy && (cpu_rd || (cpu_wr && cpu_addr[14]))) |=> cpu_busy)
		else begin
			fail_count++;
			$error("cpu_busy did not rise after an accepted CPU strobe");
		end

	set_clears: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(!ioctl_download && $past(!ioctl_download)) |-> !region_set)
		else begin
			fail_count++;
			$error("region_set still high after the download ended");
		end

endmodule

`default_nettype wire

//--- sim/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
	input wire                clk_sys,
	input wire                rst_n,
	input wire                ioctl_download,
	input wire [7:0]          ioctl_index,
	input wire                ioctl_wr,
	input wire [24:0]         ioctl_addr,
	input wire [15:0]         ioctl_data,
	input wire                ioctl_wait,
	input wire                cpu_rd,
	input wire                cpu_wr,
	input wire                cpu_bank_wr,
	input wire [14:0]         cpu_addr,
	input wire [15:0]         cpu_wdata,
	input wire [15:0]         cpu_rdata,
	input wire                cpu_busy,
	input cart_pkg::region_e  region_req,
	input wire                region_set
);

	string test_name = "reset";
	int errors = 0;
	int checks = 0;

	logic [15:0] mem_model [int]; // Only words written so far
	logic [4:0] bank_model [8];
	logic [4:0] mask_model;
	logic dl_prev;
	logic hdr_j;
	logic hdr_u;
	logic set_model;
	logic busy_prev;
	logic rd_pending;
	logic rd_known;
	logic [15:0] rd_expect;
	logic rom_dl;
	logic [14:0] phys;
	cart_pkg::region_e region_model;

	assign region_model = hdr_u ? cart_pkg::REGION_US :
		hdr_j ? cart_pkg::REGION_JP : cart_pkg::REGION_EU;

	////////////////////////////////////////
	// Compare first, then step the model
	////////////////////////////////////////

	always @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++)
				bank_model[i] = 5'(i);
			mask_model = '0;
			{dl_prev, hdr_j, hdr_u, set_model, busy_prev, rd_pending} = '0;
		end else begin
			rom_dl = ioctl_download && (ioctl_index[5:0] <= 6'd1);

			checks++;
			if (region_set !== set_model) begin
				errors++;
				$display("mismatch %s region_set: expected %b actual %b",
					test_name, set_model, region_set);
			end
			checks++;
			if (region_req !== region_model) begin
				errors++;
				$display("mismatch %s region_req: expected %0d actual %0d",
					test_name, region_model, region_req);
			end

			// Read data lands on the edge busy falls
			if (busy_prev && !cpu_busy && rd_pending) begin
				rd_pending = 1'b0;
				if (rd_known) begin
					checks++;
					if (cpu_rdata !== rd_expect) begin
						errors++;
						$display("mismatch %s cpu_rdata: expected %h actual %h",
							test_name, rd_expect, cpu_rdata);
					end
				end
			end
			busy_prev = cpu_busy;

			// CPU issue, using the bank map before this edge
			if (!cpu_busy && (cpu_rd || (cpu_wr && cpu_addr[14]))) begin
				if (cpu_addr[14])
					phys = {1'b1, cpu_addr[13:0]};
				else
					phys = {1'b0, bank_model[cpu_addr[11:9]] & mask_model, cpu_addr[8:0]};
				if (cpu_rd) begin
					rd_pending = 1'b1;
					rd_known = mem_model.exists(int'(phys));
					rd_expect = rd_known ? mem_model[int'(phys)] : 16'h0;
				end else begin
					rd_pending = 1'b0;
					mem_model[int'(phys)] = cpu_wdata;
				end
			end

			// Banks: identity on download start, else gated writes
			if (rom_dl && !dl_prev) begin
				for (int i = 0; i < 8; i++)
					bank_model[i] = 5'(i);
			end else if (cpu_bank_wr && cpu_addr[2:0] != 3'd0 && mask_model[4]) begin
				bank_model[cpu_addr[2:0]] = cpu_wdata[4:0];
			end

			if (rom_dl && ioctl_wr && !ioctl_wait) begin
				mem_model[int'({1'b0, ioctl_addr[14:1]})] = {ioctl_data[7:0], ioctl_data[15:8]};
				if (ioctl_addr == 25'd0)
					mask_model = '0;
				else
					mask_model = mask_model | ioctl_addr[14:10];
			end

			// Region flags
			if (rom_dl && !dl_prev) begin
				hdr_j = 1'b0;
				hdr_u = 1'b0;
			end
			if (rom_dl && ioctl_wr && ioctl_addr == 25'h1F0) begin
				hdr_j = (ioctl_data[7:0] == 8'h4A);
				hdr_u = (ioctl_data[7:0] == 8'h55);
				set_model = 1'b1;
			end
			if (dl_prev && !rom_dl)
				set_model = 1'b0;
			dl_prev = rom_dl;
		end
	end

	task automatic report(input int assert_fails);
		$display("checker: %0d checks, %0d errors, %0d assertion failures",
			checks, errors, assert_fails);
	endtask

endmodule

`default_nettype wire

//--- sim/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

	localparam int CLK_PERIOD = 100;
	localparam int MAX_OPS    = 2000; // Host writes plus CPU accesses, worst case
	localparam int OP_CYCLES  = 20;
	localparam int MARGIN     = 500;

	logic clk_sys;
	logic rst_n;
	logic ioctl_download;
	logic [7:0] ioctl_index;
	logic ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [15:0] ioctl_data;
	logic ioctl_wait;
	logic cpu_rd;
	logic cpu_wr;
	logic cpu_bank_wr;
	logic [14:0] cpu_addr;
	logic [15:0] cpu_wdata;
	logic [15:0] cpu_rdata;
	logic cpu_busy;
	cart_pkg::region_e region_req;
	logic region_set;
	logic [31:0] lfsr_q;
	int pages;
	logic [14:0] rom_addr;

	cart_loader_top dut_i (.*);

	tb_checker chk_i (.*);

	bind cart_loader_top cart_assertions assert_i (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wait     (ioctl_wait),
		.cpu_rd         (cpu_rd),
		.cpu_wr         (cpu_wr),
		.cpu_addr       (cpu_addr),
		.cpu_busy       (cpu_busy),
		.region_set     (region_set)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	////////////////////////////////////////
	// Bus tasks
	////////////////////////////////////////

	task automatic host_write(input logic [24:0] addr, input logic [15:0] data);
		@(negedge clk_sys);
		while (ioctl_wait)
			@(negedge clk_sys);
		@(posedge clk_sys);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= addr;
		ioctl_data <= data;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
	endtask

	// 16 words at the start of each page, then the header word
	task automatic download(input logic [7:0] index, input int npages, input logic [7:0] hdr);
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_index    <= index;
		for (int p = 0; p < npages; p++) begin
			for (int w = 0; w < 16; w++)
				host_write(25'(p * 1024 + w * 2), rand_bits(16));
		end
		host_write(25'h1F0, {8'(rand_bits(8)), hdr});
		@(negedge clk_sys);
		while (ioctl_wait)
			@(negedge clk_sys);
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic cpu_access(input logic rd, input logic [14:0] addr, input logic [15:0] data);
		@(posedge clk_sys);
		cpu_rd    <= rd;
		cpu_wr    <= !rd;
		cpu_addr  <= addr;
		cpu_wdata <= data;
		@(posedge clk_sys);
		cpu_rd <= 1'b0;
		cpu_wr <= 1'b0;
		@(negedge clk_sys);
		while (cpu_busy)
			@(negedge clk_sys); // ROM writes never raise busy
	endtask

	task automatic bank_write(input logic [2:0] idx, input logic [4:0] page);
		@(posedge clk_sys);
		cpu_bank_wr <= 1'b1;
		cpu_addr    <= {12'h000, idx};
		cpu_wdata   <= {11'h000, page};
		@(posedge clk_sys);
		cpu_bank_wr <= 1'b0;
	endtask

	task automatic rom_reads(input int count);
		for (int i = 0; i < count; i++)
			cpu_access(1'b1, {3'b000, 3'(rand_bits(3)), 5'h00, 4'(rand_bits(4))}, 16'h0);
	endtask

	// Every word that the download task wrote, page by page
	task automatic rom_sweep(input int npages);
		for (int p = 0; p < npages; p++) begin
			for (int w = 0; w < 16; w++)
				cpu_access(1'b1, {3'b000, 3'(p), 5'h00, 4'(w)}, 16'h0);
		end
	endtask

	function automatic logic [7:0] other_region_byte();
		logic [7:0] b;
		b = rand_bits(8);
		if (b == 8'h4A || b == 8'h55)
			b = 8'h45;
		return b;
	endfunction

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		lfsr_q = 32'd96412;
		rst_n = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index = 8'h00;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_data = '0;
		cpu_rd = 1'b0;
		cpu_wr = 1'b0;
		cpu_bank_wr = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		repeat (5) @(posedge clk_sys);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk_sys);

		chk_i.test_name = "rom_load";
		pages = 1 + int'(rand_bits(5));
		download(8'h00, pages, 8'h4A);
		rom_reads(64);

		chk_i.test_name = "region";
		download(8'h00, 2, 8'h4A);
		download(8'h01, 2, 8'h55);
		download(8'h00, 2, other_region_byte());

		chk_i.test_name = "bank_large";
		pages = 17 + int'(rand_bits(4));
		download(8'h00, pages, 8'h55);
		for (int i = 0; i < 32; i++) begin
			bank_write(rand_bits(3), rand_bits(5));
			rom_reads(2);
		end

		chk_i.test_name = "index3";
		download(8'h03, 1, 8'h4A);
		rom_reads(16);

		chk_i.test_name = "bank_small";
		download(8'h00, 8, 8'h4A);
		for (int i = 0; i < 8; i++)
			bank_write(rand_bits(3), rand_bits(5));
		rom_reads(32);

		chk_i.test_name = "work_ram";
		for (int i = 0; i < 64; i++)
			cpu_access(rand_bits(1), {1'b1, 9'h000, 5'(rand_bits(5))}, rand_bits(16));
		for (int i = 0; i < 4; i++) begin
			rom_addr = {3'b000, 3'(rand_bits(3)), 5'h00, 4'(rand_bits(4))};
			cpu_access(1'b0, rom_addr, rand_bits(16));
			cpu_access(1'b1, rom_addr, 16'h0); // Still the image word
		end
		rom_reads(16);

		chk_i.test_name = "contention";
		fork
			download(8'h01, 4, 8'h55);
			for (int i = 0; i < 40; i++)
				cpu_access(rand_bits(1), {1'b1, 8'h00, 6'(rand_bits(6))}, rand_bits(16));
		join
		rom_sweep(4);

		repeat (5) @(posedge clk_sys);
		chk_i.report(dut_i.assert_i.fail_count);
		if (chk_i.errors == 0 && dut_i.assert_i.fail_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (MAX_OPS * OP_CYCLES + MARGIN) @(posedge clk_sys);
		$display("timeout: the tests did not finish within %0d cycles",
			MAX_OPS * OP_CYCLES + MARGIN);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
rtl/cart_pkg.sv
rtl/word_ram.sv
rtl/mem_arbiter.sv
rtl/rom_loader.sv
rtl/cart_header.sv
rtl/bank_mapper.sv
rtl/cart_loader_top.sv
sim/tb_assertions.sv
sim/tb_checker.sv
sim/tb_top.sv

//--- run.sh
#!/bin/sh
# Compile and run the cartridge loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_top -f list.f -o tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Testbench failed" sim.log; then
	exit 1
fi
exit 0
